//--- verilog/rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// data path width.
`define RV_XLEN 32

// register index width.
`define RV_REGW 5

// addi x0, x0, 0 is decoded whenever no packet is presented.
`define RV_INSTR_NOP 32'h0000_0013

`endif

//--- verilog/rv32i_pkg.sv
`include "rv32i_consts.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0] rv_word_t;

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011
    } rv_opcode_e;

    // one struct per encoding format, each 32 bits.
    typedef struct packed {
        logic [6:0]          funct7;
        logic [`RV_REGW-1:0] rs2;
        logic [`RV_REGW-1:0] rs1;
        logic [2:0]          funct3;
        logic [`RV_REGW-1:0] rd;
        logic [6:0]          opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]         imm;
        logic [`RV_REGW-1:0] rs1;
        logic [2:0]          funct3;
        logic [`RV_REGW-1:0] rd;
        logic [6:0]          opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]          imm_hi;
        logic [`RV_REGW-1:0] rs2;
        logic [`RV_REGW-1:0] rs1;
        logic [2:0]          funct3;
        logic [4:0]          imm_lo;
        logic [6:0]          opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                imm12;
        logic [5:0]          imm10_5;
        logic [`RV_REGW-1:0] rs2;
        logic [`RV_REGW-1:0] rs1;
        logic [2:0]          funct3;
        logic [3:0]          imm4_1;
        logic                imm11;
        logic [6:0]          opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]         imm;
        logic [`RV_REGW-1:0] rd;
        logic [6:0]          opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                imm20;
        logic [9:0]          imm10_1;
        logic                imm11;
        logic [7:0]          imm19_12;
        logic [`RV_REGW-1:0] rd;
        logic [6:0]          opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_instr_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // same codes as the branch funct3 field.
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {wb_alu, wb_pc_plus4, wb_imm} wb_sel_e;

    typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_jump_lsb0} pc_sel_e;

    typedef struct packed {
        rv_word_t  pc;
        rv_instr_u instr;
        rv_word_t  rs1_val;
        rv_word_t  rs2_val;
    } ex_issue_t;

    typedef struct packed {
        rv_word_t            pc;
        logic [`RV_REGW-1:0] rd;
        rv_word_t            a;
        rv_word_t            b;
        rv_word_t            cmp_a;
        rv_word_t            cmp_b;
        rv_word_t            imm;
        alu_op_e             alu_op;
        cmp_op_e             cmp_op;
        wb_sel_e             wb_sel;
        pc_sel_e             pc_sel;
        logic                we;
        logic                illegal;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`RV_REGW-1:0] rd;
        rv_word_t            wdata;
        logic                we;
        rv_word_t            next_pc;
        logic                taken;
        logic                illegal;
    } ex_result_t;

endpackage

//--- verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  rv32i_pkg::ex_ctrl_t ctrl_i,
    output rv32i_pkg::rv_word_t alu_res_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = ctrl_i.b[4:0];
    assign lt_s  = $signed(ctrl_i.a) < $signed(ctrl_i.b);
    assign lt_u  = ctrl_i.a < ctrl_i.b;

    always_comb begin
        case (ctrl_i.alu_op)
            rv32i_pkg::alu_add:  alu_res_o = ctrl_i.a + ctrl_i.b;
            rv32i_pkg::alu_sub:  alu_res_o = ctrl_i.a - ctrl_i.b;
            rv32i_pkg::alu_sll:  alu_res_o = ctrl_i.a << shamt;
            rv32i_pkg::alu_slt:  alu_res_o = {31'b0, lt_s};
            rv32i_pkg::alu_sltu: alu_res_o = {31'b0, lt_u};
            rv32i_pkg::alu_xor:  alu_res_o = ctrl_i.a ^ ctrl_i.b;
            rv32i_pkg::alu_srl:  alu_res_o = ctrl_i.a >> shamt;
            rv32i_pkg::alu_sra:  alu_res_o = $signed(ctrl_i.a) >>> shamt;
            rv32i_pkg::alu_or:   alu_res_o = ctrl_i.a | ctrl_i.b;
            rv32i_pkg::alu_and:  alu_res_o = ctrl_i.a & ctrl_i.b;
            default:             alu_res_o = '0;
        endcase
    end

    // decode only ever emits the ten listed codes; an unloaded register may still be x.
    always_comb begin
        a_alu_op_known: assert final ($isunknown(ctrl_i.alu_op) ||
                                      ctrl_i.alu_op <= rv32i_pkg::alu_and);
    end

endmodule

//--- verilog/ex_branch_cmp.sv
`timescale 1ns/1ps

module ex_branch_cmp (
    input  rv32i_pkg::ex_ctrl_t ctrl_i,
    output logic                taken_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (ctrl_i.cmp_a == ctrl_i.cmp_b);
    assign lt_s = $signed(ctrl_i.cmp_a) < $signed(ctrl_i.cmp_b);
    assign lt_u = ctrl_i.cmp_a < ctrl_i.cmp_b;

    always_comb begin
        case (ctrl_i.cmp_op)
            rv32i_pkg::cmp_beq:  cond = eq;
            rv32i_pkg::cmp_bne:  cond = ~eq;
            rv32i_pkg::cmp_blt:  cond = lt_s;
            rv32i_pkg::cmp_bge:  cond = ~lt_s;
            rv32i_pkg::cmp_bltu: cond = lt_u;
            rv32i_pkg::cmp_bgeu: cond = ~lt_u;
            default:             cond = 1'b0;
        endcase
    end

    // only branches can be taken.
    assign taken_o = (ctrl_i.pc_sel == rv32i_pkg::pc_branch) && cond;

endmodule

//--- verilog/ex_decode.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module ex_decode (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    input  rv32i_pkg::ex_issue_t in_data_i,
    output logic                 in_ready_o,
    input  logic                 adv_i,
    output logic                 ctrl_valid_o,
    output rv32i_pkg::ex_ctrl_t  ctrl_o
);

    rv32i_pkg::rv_instr_u instr;
    rv32i_pkg::rv_word_t  i_imm, s_imm, b_imm, u_imm, j_imm;
    rv32i_pkg::alu_op_e   arith_op;
    rv32i_pkg::ex_ctrl_t  ctrl_d;
    logic                 rd_nz;
    logic                 load;

    // bubbles decode as a nop so the register never sees garbage.
    assign instr = in_valid_i ? in_data_i.instr : `RV_INSTR_NOP;

    assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign s_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign u_imm = {instr.u.imm, 12'b0};
    assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    assign rd_nz = (instr.r.rd != '0);

    // funct7[5] picks sub only for register ops; sra for both.
    always_comb begin
        case (instr.r.funct3)
            3'b000: arith_op = (instr.r.opcode == rv32i_pkg::op_reg && instr.r.funct7[5]) ?
                               rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            3'b001: arith_op = rv32i_pkg::alu_sll;
            3'b010: arith_op = rv32i_pkg::alu_slt;
            3'b011: arith_op = rv32i_pkg::alu_sltu;
            3'b100: arith_op = rv32i_pkg::alu_xor;
            3'b101: arith_op = instr.r.funct7[5] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110: arith_op = rv32i_pkg::alu_or;
            default: arith_op = rv32i_pkg::alu_and;
        endcase
    end

    always_comb begin
        ctrl_d.pc      = in_data_i.pc;
        ctrl_d.rd      = instr.r.rd;
        ctrl_d.a       = in_data_i.rs1_val;
        ctrl_d.b       = in_data_i.rs2_val;
        ctrl_d.cmp_a   = in_data_i.rs1_val;
        ctrl_d.cmp_b   = in_data_i.rs2_val;
        ctrl_d.imm     = s_imm;                  // store-shaped default.
        ctrl_d.alu_op  = rv32i_pkg::alu_add;
        ctrl_d.cmp_op  = rv32i_pkg::cmp_beq;
        ctrl_d.wb_sel  = rv32i_pkg::wb_alu;
        ctrl_d.pc_sel  = rv32i_pkg::pc_seq;
        ctrl_d.we      = rd_nz;
        ctrl_d.illegal = 1'b0;
        case (instr.r.opcode)
            rv32i_pkg::op_reg: begin
                ctrl_d.alu_op = arith_op;
            end
            rv32i_pkg::op_imm: begin
                ctrl_d.b      = i_imm;
                ctrl_d.imm    = i_imm;
                ctrl_d.alu_op = arith_op;
            end
            rv32i_pkg::op_lui: begin
                ctrl_d.imm    = u_imm;
                ctrl_d.wb_sel = rv32i_pkg::wb_imm;
            end
            rv32i_pkg::op_auipc: begin
                ctrl_d.a   = in_data_i.pc;
                ctrl_d.b   = u_imm;
                ctrl_d.imm = u_imm;
            end
            rv32i_pkg::op_jal: begin
                ctrl_d.a      = in_data_i.pc;
                ctrl_d.b      = j_imm;
                ctrl_d.imm    = j_imm;
                ctrl_d.wb_sel = rv32i_pkg::wb_pc_plus4;
                ctrl_d.pc_sel = rv32i_pkg::pc_jump;
            end
            rv32i_pkg::op_jalr: begin
                ctrl_d.b      = i_imm;
                ctrl_d.imm    = i_imm;
                ctrl_d.wb_sel = rv32i_pkg::wb_pc_plus4;
                ctrl_d.pc_sel = rv32i_pkg::pc_jump_lsb0;
            end
            rv32i_pkg::op_br: begin
                ctrl_d.imm    = b_imm;
                ctrl_d.pc_sel = rv32i_pkg::pc_branch;
                ctrl_d.we     = 1'b0;
                case (instr.b.funct3)
                    3'b001: ctrl_d.cmp_op = rv32i_pkg::cmp_bne;
                    3'b100: ctrl_d.cmp_op = rv32i_pkg::cmp_blt;
                    3'b101: ctrl_d.cmp_op = rv32i_pkg::cmp_bge;
                    3'b110: ctrl_d.cmp_op = rv32i_pkg::cmp_bltu;
                    3'b111: ctrl_d.cmp_op = rv32i_pkg::cmp_bgeu;
                    default: ctrl_d.cmp_op = rv32i_pkg::cmp_beq;
                endcase
            end
            default: begin
                ctrl_d.we      = 1'b0;
                ctrl_d.illegal = 1'b1;
            end
        endcase
    end

    assign load       = ~ctrl_valid_o | adv_i;
    assign in_ready_o = load;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_valid_o <= 1'b0;
        end else if (load) begin
            ctrl_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            ctrl_o <= ctrl_d;
        end
    end

    // a stalled item must stay put until result_sel takes it.
    a_ctrl_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl_valid_o && !adv_i |=> ctrl_valid_o && $stable(ctrl_o));

endmodule

//--- verilog/ex_result_sel.sv
`timescale 1ns/1ps

module ex_result_sel (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  ctrl_valid_i,
    input  rv32i_pkg::ex_ctrl_t   ctrl_i,
    input  rv32i_pkg::rv_word_t   alu_res_i,
    input  logic                  taken_i,
    output logic                  adv_o,
    output logic                  out_valid_o,
    output rv32i_pkg::ex_result_t out_data_o,
    input  logic                  out_ready_i
);

    rv32i_pkg::rv_word_t   pc_plus4;
    rv32i_pkg::rv_word_t   br_target;
    rv32i_pkg::ex_result_t res_d;

    assign pc_plus4  = ctrl_i.pc + 32'd4;
    assign br_target = ctrl_i.pc + ctrl_i.imm;

    always_comb begin
        res_d.rd      = ctrl_i.rd;
        res_d.we      = ctrl_i.we;
        res_d.taken   = taken_i;
        res_d.illegal = ctrl_i.illegal;

        case (ctrl_i.pc_sel)
            rv32i_pkg::pc_branch:    res_d.next_pc = taken_i ? br_target : pc_plus4;
            rv32i_pkg::pc_jump:      res_d.next_pc = alu_res_i;
            rv32i_pkg::pc_jump_lsb0: res_d.next_pc = alu_res_i & 32'hFFFF_FFFE;
            default:                 res_d.next_pc = pc_plus4;
        endcase

        case (ctrl_i.wb_sel)
            rv32i_pkg::wb_pc_plus4: res_d.wdata = pc_plus4;
            rv32i_pkg::wb_imm:      res_d.wdata = ctrl_i.imm;   // lui.
            default:                res_d.wdata = alu_res_i;
        endcase
    end

    // room when empty or the sink takes the current item this edge.
    assign adv_o = ~out_valid_o | out_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (adv_o) begin
            out_valid_o <= ctrl_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (adv_o && ctrl_valid_i) begin
            out_data_o <= res_d;
        end
    end

    a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  in_valid_i,
    input  rv32i_pkg::ex_issue_t  in_data_i,
    output logic                  in_ready_o,

    output logic                  out_valid_o,
    output rv32i_pkg::ex_result_t out_data_o,
    input  logic                  out_ready_i
);

    rv32i_pkg::ex_ctrl_t ctrl;
    rv32i_pkg::rv_word_t alu_res;
    logic                ctrl_valid;
    logic                cmp_taken;
    logic                adv;

    ex_decode u_decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .in_ready_o   (in_ready_o),
        .adv_i        (adv),
        .ctrl_valid_o (ctrl_valid),
        .ctrl_o       (ctrl)
    );

    ex_alu u_alu (
        .ctrl_i    (ctrl),
        .alu_res_o (alu_res)
    );

    ex_branch_cmp u_cmp (
        .ctrl_i  (ctrl),
        .taken_o (cmp_taken)
    );

    // second register stage, also the source of back-pressure.
    ex_result_sel u_result (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl_valid_i (ctrl_valid),
        .ctrl_i       (ctrl),
        .alu_res_i    (alu_res),
        .taken_i      (cmp_taken),
        .adv_o        (adv),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

//--- bench/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

logic [31:0] lfsr_state = 32'h0001_0861;

// galois lfsr, x^32 + x^22 + x^2 + x + 1.
function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
        v = {v[30:0], rand_bit()};
    return v;
endfunction

// expected result of one issue packet, straight from the rv32i encoding.
function automatic rv32i_pkg::ex_result_t ref_execute(input rv32i_pkg::ex_issue_t it);
    rv32i_pkg::ex_result_t r;
    logic [31:0] w, a, b, op2, pc4, iimm, bimm, uimm, jimm, alu;
    logic [4:0]  sh;
    logic        t;
    w    = it.instr;
    a    = it.rs1_val;
    b    = it.rs2_val;
    pc4  = it.pc + 32'd4;
    iimm = {{20{w[31]}}, w[31:20]};
    bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    uimm = {w[31:12], 12'b0};
    jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    r.rd      = w[11:7];
    r.we      = (w[11:7] != 5'd0);
    r.wdata   = '0;
    r.next_pc = pc4;
    r.taken   = 1'b0;
    r.illegal = 1'b0;
    case (w[6:0])
        7'h33, 7'h13: begin
            op2 = (w[6:0] == 7'h33) ? b : iimm;
            sh  = op2[4:0];
            case (w[14:12])
                3'd0: alu = (w[6:0] == 7'h33 && w[30]) ? a - op2 : a + op2;
                3'd1: alu = a << sh;
                3'd2: alu = {31'b0, $signed(a) < $signed(op2)};
                3'd3: alu = {31'b0, a < op2};
                3'd4: alu = a ^ op2;
                3'd5: begin
                    if (w[30])
                        alu = $signed(a) >>> sh;   // arithmetic.
                    else
                        alu = a >> sh;
                end
                3'd6: alu = a | op2;
                default: alu = a & op2;
            endcase
            r.wdata = alu;
        end
        7'h37: r.wdata = uimm;
        7'h17: r.wdata = it.pc + uimm;
        7'h6f: begin
            r.wdata   = pc4;
            r.next_pc = it.pc + jimm;
        end
        7'h67: begin
            r.wdata   = pc4;
            r.next_pc = (a + iimm) & 32'hFFFF_FFFE;
        end
        7'h63: begin
            case (w[14:12])
                3'd0: t = (a == b);
                3'd1: t = (a != b);
                3'd4: t = $signed(a) < $signed(b);
                3'd5: t = $signed(a) >= $signed(b);
                3'd6: t = a < b;
                3'd7: t = a >= b;
                default: t = 1'b0;
            endcase
            r.we      = 1'b0;
            r.taken   = t;
            r.next_pc = t ? it.pc + bimm : pc4;
        end
        default: begin
            r.we      = 1'b0;
            r.illegal = 1'b1;
        end
    endcase
    return r;
endfunction

`endif

//--- bench/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int ITEMS        = 48;
    localparam int TESTS        = 6;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = ITEMS * TESTS * 8 + RESET_CYCLES;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    rv32i_pkg::ex_issue_t  in_data;
    logic                  in_ready;
    logic                  out_valid;
    rv32i_pkg::ex_result_t out_data;
    logic                  out_ready;

    logic  bp;                               // random back-pressure on.
    logic  ready_exp;
    logic  valid_exp;
    int    cycle = 0;
    int    checks = 0;
    int    errors = 0;
    int    err0;
    int    acc_c;
    int    acc_q[$];
    rv32i_pkg::ex_result_t exp_q[$];
    string names[TESTS] = '{"op", "imm_lui_auipc", "branch", "jal_jalr",
                            "backpressure", "x0_illegal"};

    `include "ex_ref_model.svh"

    ex_stage u_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_valid_i  (in_valid),
        .in_data_i   (in_data),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_data_o  (out_data),
        .out_ready_i (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic is_supported(input logic [6:0] op);
        return op inside {7'h33, 7'h13, 7'h37, 7'h17, 7'h6f, 7'h67, 7'h63};
    endfunction

    // class 0 op, 1 op-imm/lui/auipc, 2 branch, 3 jal/jalr.
    function automatic logic [31:0] base_instr(input int cls, input int i);
        logic [31:0] w;
        logic [2:0]  f3;
        int          k;
        w  = rand_bits(32);
        f3 = i[2:0];
        k  = i % 6;
        case (cls)
            0: begin
                w[6:0]   = 7'h33;
                w[14:12] = f3;
                w[31:25] = (i[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            end
            1: begin
                if (i % 3 == 0) begin
                    w[6:0]   = 7'h13;
                    w[14:12] = f3;
                    if (f3 == 3'd1 || f3 == 3'd5)
                        w[31:25] = (i[3] && f3 == 3'd5) ? 7'h20 : 7'h00;
                end else begin
                    w[6:0] = (i % 3 == 1) ? 7'h37 : 7'h17;
                end
            end
            2: begin
                w[6:0]   = 7'h63;
                w[14:12] = (k < 2) ? k[2:0] : k[2:0] + 3'd2;   // skip 2 and 3.
            end
            default: begin
                w[6:0] = i[0] ? 7'h67 : 7'h6f;
                if (i[0])
                    w[14:12] = 3'b000;
            end
        endcase
        return w;
    endfunction

    function automatic rv32i_pkg::ex_issue_t make_issue(input int t, input int i);
        logic [31:0] w, pc, rs1, rs2;
        if (t == 4) begin
            w = base_instr(int'(rand_bits(2)), i);
        end else if (t == 5 && i[0]) begin
            do
                w = rand_bits(32);
            while (is_supported(w[6:0]));
        end else if (t == 5) begin
            w = base_instr((i / 2) % 4, i);
            w[11:7] = 5'd0;
        end else begin
            w = base_instr(t, i);
        end
        pc  = rand_bits(32);
        pc[1:0] = 2'b00;
        rs1 = rand_bits(32);
        rs2 = rand_bits(32);
        if (w[6:0] == 7'h63 && rand_bit())
            rs2 = rs1;
        return {pc, w, rs1, rs2};
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_result(input rv32i_pkg::ex_result_t got,
                                  input rv32i_pkg::ex_result_t exp);
        check_val("we", {31'b0, got.we}, {31'b0, exp.we});
        check_val("illegal", {31'b0, got.illegal}, {31'b0, exp.illegal});
        check_val("taken", {31'b0, got.taken}, {31'b0, exp.taken});
        check_val("next_pc", got.next_pc, exp.next_pc);
        if (exp.we) begin
            check_val("rd", {27'b0, got.rd}, {27'b0, exp.rd});
            check_val("wdata", got.wdata, exp.wdata);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        out_ready = bp ? rand_bit() : 1'b1;
    endtask

    task automatic send_item(input rv32i_pkg::ex_issue_t p);
        logic acc;
        while (bp && rand_bit())
            next_cycle();
        in_valid = 1'b1;
        in_data  = p;
        do begin
            @(negedge clk);
            acc = in_ready;
            next_cycle();
        end while (!acc);
        in_valid = 1'b0;
    endtask

    // scoreboard sampled mid-cycle where every signal is settled.
    always @(negedge clk) begin
        if (rst_n) begin
            // two items in flight fill both stages.
            ready_exp = (exp_q.size() < 2) || out_ready;
            valid_exp = 1'b0;
            if (acc_q.size() != 0)
                valid_exp = (cycle - acc_q[0] >= 2);
            check_val("in_ready", {31'b0, in_ready}, {31'b0, ready_exp});
            check_val("out_valid", {31'b0, out_valid}, {31'b0, valid_exp});
        end
        if (rst_n && in_valid && in_ready) begin
            exp_q.push_back(ref_execute(in_data));
            acc_q.push_back(cycle);
        end
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected output at %0t with no item pending", $time);
            end else begin
                compare_result(out_data, exp_q.pop_front());
                acc_c = acc_q.pop_front();
                if (!bp)
                    check_val("latency", cycle - acc_c, 32'd2);
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        bp        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < TESTS; t++) begin
            err0      = errors;
            bp        = (t == 4);
            out_ready = 1'b1;
            for (int i = 0; i < ITEMS; i++)
                send_item(make_issue(t, i));
            for (int k = 0; k < 64 && exp_q.size() != 0; k++)
                next_cycle();
            bp = 1'b0;
            $display("test %0d %s: %0d items, %0d errors", t, names[t], ITEMS, errors - err0);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d accepted items never came out", exp_q.size());
        end
        $display("tests %0d, checks %0d, errors %0d", TESTS, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- list.f
+incdir+verilog
+incdir+bench
verilog/rv32i_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch_cmp.sv
verilog/ex_decode.sv
verilog/ex_result_sel.sv
verilog/ex_stage.sv
bench/ex_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
